// ==== common/mem_pkg.sv ====
// shared types for the memory access unit
// byte-addressed 24-bit core side, 16-bit byte-laned RAM side
// RAM size defaults to 2**ADDR_W words; top level may override

package mem_pkg;

    // default RAM word index width (4096 x 16)
    localparam int ADDR_W = 12;

    // memory opcodes; sized loads come zero- or sign-extended
    typedef enum logic [3:0] {
        op_fetch = 4'd0,  // four-byte window at the fetch address
        op_ld8   = 4'd1,
        op_ld16  = 4'd2,
        op_ld32  = 4'd3,
        op_ld8s  = 4'd4,
        op_ld16s = 4'd5,
        op_st8   = 4'd6,
        op_st16  = 4'd7,
        op_st32  = 4'd8
    } mem_op_e;

    // one command as presented at the unit input
    typedef struct packed {
        mem_op_e     op;
        logic [23:0] addr;   // byte address
        logic [31:0] wdata;  // store data, low byte first in memory
    } mem_req_t;

    // controller to RAM
    typedef struct packed {
        logic [23:0] addr;  // byte address, bit 0 ignored by the RAM
        logic [15:0] din;
        logic [1:0]  we;    // lane enables, [1] high byte, [0] low byte
    } ram_port_t;

endpackage

// ==== ramctl/mem_ram.sv ====
// 16-bit RAM, combinational read, per-lane write on the clock
// addresses wrap modulo 2**ADDR_W words; contents start at zero

module mem_ram #(
    parameter int ADDR_W = mem_pkg::ADDR_W
) (
    input  logic               clk,
    input  mem_pkg::ram_port_t ram,
    output logic [15:0]        ram_dout
);

    logic [15:0]       mem [0:2**ADDR_W-1];
    logic [ADDR_W-1:0] widx;

    assign widx     = ram.addr[ADDR_W:1];  // drop byte select, wrap
    assign ram_dout = mem[widx];

    // FPGA power-up contents
    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = 16'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (ram.we[0]) begin
            mem[widx][7:0] <= ram.din[7:0];  // even address
        end
        if (ram.we[1]) begin
            mem[widx][15:8] <= ram.din[15:8];
        end
    end

endmodule

// ==== ramctl/mem_ramctl.sv ====
// keeps a four-byte read window and splits writes into 16-bit lane beats
// RAM must answer in the same cycle (no wait states)
// one access at a time; any write beat throws the window away

module mem_ramctl (
    input  logic               clk,
    input  logic               rst,
    input  logic               ldram_en,  // 1 load address, 0 fetch address
    input  logic [23:0]        idx_addr,
    input  logic [23:0]        pc,
    input  logic [31:0]        reg_dout,
    input  logic               idx_wr,    // write starts on its rising edge
    input  logic [2:0]         len,       // one-hot byte / word / long
    input  logic [15:0]        ram_dout,
    output mem_pkg::ram_port_t ram,
    output logic [31:0]        dout,
    output logic               ram_rdy,
    output logic               wr_done
);

    logic [3:0][7:0] win;       // byte k sits at win_addr + k
    logic [23:0]     win_addr;
    logic [3:0]      win_ok;
    logic [3:0]      fill;      // bytes still to be fetched
    logic [3:0]      take;
    logic [23:0]     req_addr;
    logic            odd;
    logic [7:0]      even_b;    // RAM byte for window slots 0 and 2
    logic [7:0]      odd_b;     // RAM byte for window slots 1 and 3
    logic            idx_wr_l;
    logic [1:0]      wr_beat;   // next beat number, 0 when idle

    assign req_addr = ldram_en ? idx_addr : pc;
    assign ram_rdy  = &win_ok && win_addr == req_addr;  // win_ok is clear during write beats
    assign dout     = win;

    // steering follows the parity of the window base
    assign odd    = win_addr[0];
    assign even_b = odd ? ram_dout[15:8] : ram_dout[7:0];
    assign odd_b  = odd ? ram_dout[7:0] : ram_dout[15:8];

    // which pending bytes are present in the word on the bus now
    assign take[0] = fill[0];
    assign take[1] = fill[1] && (!odd || !fill[0]);
    assign take[2] = fill[2] && !fill[0] && (!fill[1] || odd);
    assign take[3] = fill[3] && !fill[1] && (!odd || !fill[2]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram      <= '0;
            win      <= '0;
            win_addr <= '0;
            win_ok   <= '0;
            fill     <= '0;
            idx_wr_l <= 1'b0;
            wr_beat  <= 2'd0;
            wr_done  <= 1'b0;
        end else begin
            idx_wr_l <= idx_wr;
            wr_done  <= 1'b0;
            ram.we   <= 2'b00;
            if (idx_wr) begin
                win_ok <= '0;  // window may hold the bytes being written
                fill   <= '0;
                if (!idx_wr_l) begin
                    ram.addr <= idx_addr;
                    ram.din  <= (len[0] || idx_addr[0]) ? {2{reg_dout[7:0]}}
                                                         : reg_dout[15:0];
                    if (len[0]) begin
                        ram.we <= {idx_addr[0], ~idx_addr[0]};
                    end else begin
                        ram.we <= idx_addr[0] ? 2'b10 : 2'b11;
                    end
                    if ((idx_addr[0] && len[1]) || len[2]) begin
                        wr_beat <= 2'd1;
                    end else begin
                        wr_done <= 1'b1;  // single beat
                    end
                end else if (wr_beat == 2'd1) begin
                    ram.addr <= ram.addr + 24'd2;
                    if (idx_addr[0] && len[2]) begin  // odd long, middle word
                        ram.din <= reg_dout[23:8];
                        ram.we  <= 2'b11;
                        wr_beat <= 2'd2;
                    end else begin
                        // odd word tail or even long upper half
                        ram.din <= idx_addr[0] ? {2{reg_dout[15:8]}} : reg_dout[31:16];
                        ram.we  <= idx_addr[0] ? 2'b01 : 2'b11;
                        wr_beat <= 2'd0;
                        wr_done <= 1'b1;
                    end
                end else if (wr_beat == 2'd2) begin
                    ram.addr <= ram.addr + 24'd2;
                    ram.din  <= {2{reg_dout[31:24]}};
                    ram.we   <= 2'b01;  // top byte lands on an even address
                    wr_beat  <= 2'd0;
                    wr_done  <= 1'b1;
                end
            end else begin
                if (fill != 4'd0) begin
                    ram.addr <= ram.addr + 24'd2;
                    for (int k = 0; k < 4; k++) begin
                        if (take[k]) begin
                            win[k]    <= (k % 2 == 1) ? odd_b : even_b;
                            win_ok[k] <= 1'b1;
                            fill[k]   <= 1'b0;
                        end
                    end
                end
                if (fill == 4'd0 && (req_addr != win_addr || win_ok != 4'hf)) begin
                    if (req_addr == win_addr + 24'd1 && win_ok[3:1] == 3'b111) begin
                        win_addr <= req_addr;
                        win      <= {8'd0, win[3:1]};
                        ram.addr <= req_addr + 24'd3;
                        fill     <= 4'b1000;
                        win_ok   <= 4'b0111;
                    end else if (req_addr == win_addr + 24'd2 && win_ok[3:2] == 2'b11) begin
                        win_addr <= req_addr;
                        win[1:0] <= win[3:2];
                        ram.addr <= req_addr + 24'd2;
                        fill     <= 4'b1100;
                        win_ok   <= 4'b0011;
                    end else if (req_addr == win_addr + 24'd3 && win_ok[3]) begin
                        win_addr <= req_addr;
                        win[0]   <= win[3];
                        ram.addr <= req_addr + {23'd0, req_addr[0]};  // word holding byte 1
                        fill     <= 4'b1110;
                        win_ok   <= 4'b0001;
                    end else begin
                        // cold refill
                        win_addr <= req_addr;
                        ram.addr <= req_addr;
                        fill     <= 4'b1111;
                        win_ok   <= 4'b0000;
                    end
                end
            end
        end
    end

endmodule

// ==== src/mem_decode.sv ====
// takes one command at a time and drives the RAM controller until done
// strobes arriving while busy are dropped; unknown opcodes end without done

module mem_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  mem_pkg::mem_req_t cmd,
    input  logic              ram_rdy,
    input  logic              wr_done,
    output logic              busy,
    output logic              ldram_en,
    output logic [23:0]       idx_addr,
    output logic [23:0]       pc,
    output logic [2:0]        len,
    output logic              idx_wr,
    output logic [31:0]       reg_dout,
    output mem_pkg::mem_op_e  op,
    output logic              capture
);

    typedef enum logic [1:0] {idle, read, write, finish} state_e;

    state_e state;

    assign busy    = state != idle;
    assign capture = state == read && ram_rdy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            ldram_en <= 1'b0;
            idx_wr   <= 1'b0;
            idx_addr <= '0;
            pc       <= '0;
        end else begin
            case (state)
                idle: if (cmd_valid) begin
                    case (cmd.op)
                        mem_pkg::op_fetch: begin
                            pc       <= cmd.addr;
                            ldram_en <= 1'b0;
                            state    <= read;
                        end
                        mem_pkg::op_ld8, mem_pkg::op_ld16, mem_pkg::op_ld32,
                        mem_pkg::op_ld8s, mem_pkg::op_ld16s: begin
                            idx_addr <= cmd.addr;
                            ldram_en <= 1'b1;
                            state    <= read;
                        end
                        mem_pkg::op_st8, mem_pkg::op_st16, mem_pkg::op_st32: begin
                            idx_addr <= cmd.addr;
                            idx_wr   <= 1'b1;
                            state    <= write;
                        end
                        default: state <= finish;
                    endcase
                end
                read:  if (ram_rdy) state <= finish;
                write: if (wr_done) begin
                    idx_wr <= 1'b0;  // gap for the write edge detector
                    state  <= finish;
                end
                default: state <= idle;  // finish, done cycle
            endcase
        end
    end

    // command payload
    always_ff @(posedge clk) begin
        if (state == idle && cmd_valid) begin
            op       <= cmd.op;
            reg_dout <= cmd.wdata;
            case (cmd.op)
                mem_pkg::op_ld8, mem_pkg::op_ld8s, mem_pkg::op_st8:    len <= 3'b001;
                mem_pkg::op_ld16, mem_pkg::op_ld16s, mem_pkg::op_st16: len <= 3'b010;
                default:                                              len <= 3'b100;
            endcase
        end
    end

endmodule

// ==== src/mem_result.sv ====
// sizes the read window into the result and pulses done
// rdata is zero on the done of a store

module mem_result (
    input  logic             clk,
    input  logic             rst,
    input  logic             capture,  // window is ready this cycle
    input  mem_pkg::mem_op_e op,
    input  logic [31:0]      dout,
    input  logic             wr_done,
    output logic             done,
    output logic [31:0]      rdata
);

    logic [31:0] sized;

    always_comb begin
        case (op)
            mem_pkg::op_ld8:   sized = {24'd0, dout[7:0]};
            mem_pkg::op_ld8s:  sized = {{24{dout[7]}}, dout[7:0]};
            mem_pkg::op_ld16:  sized = {16'd0, dout[15:0]};
            mem_pkg::op_ld16s: sized = {{16{dout[15]}}, dout[15:0]};
            default:           sized = dout;  // fetch and ld32
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done  <= 1'b0;
            rdata <= '0;
        end else begin
            done <= capture || wr_done;
            if (capture) begin
                rdata <= sized;
            end else if (wr_done) begin
                rdata <= '0;
            end
        end
    end

endmodule

// ==== src/mem_unit_top.sv ====
// memory access unit: decode, RAM controller with RAM, result
// one command in flight; cmd_valid is taken only while busy is low

module mem_unit_top #(
    parameter int ADDR_W = mem_pkg::ADDR_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  mem_pkg::mem_req_t cmd,
    output logic              busy,
    output logic              done,
    output logic [31:0]       rdata
);

    logic               ldram_en;
    logic [23:0]        idx_addr;
    logic [23:0]        pc;
    logic [2:0]         len;
    logic               idx_wr;
    logic [31:0]        reg_dout;
    mem_pkg::mem_op_e   op;
    logic               capture;
    logic               ram_rdy;
    logic               wr_done;
    logic [31:0]        dout;
    mem_pkg::ram_port_t ram;
    logic [15:0]        ram_dout;

    mem_decode u_decode (
        .clk, .rst, .cmd_valid, .cmd, .ram_rdy, .wr_done, .busy, .ldram_en,
        .idx_addr, .pc, .len, .idx_wr, .reg_dout, .op, .capture
    );

    mem_ramctl u_ramctl (
        .clk, .rst, .ldram_en, .idx_addr, .pc, .reg_dout, .idx_wr, .len,
        .ram_dout, .ram, .dout, .ram_rdy, .wr_done
    );

    mem_ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk, .ram, .ram_dout
    );

    mem_result u_result (
        .clk, .rst, .capture, .op, .dout, .wr_done, .done, .rdata
    );

endmodule

// ==== tb/mem_unit_tb.sv ====
// replays tb/mem_golden.txt against the memory unit; run from the project root
// one command per golden line, each done checked against the expected rdata

module mem_unit_tb;

    localparam int MAX_LINES    = 64;
    localparam int RESET_CYCLES = 5;

    logic              clk;
    logic              rst;
    logic              cmd_valid;
    mem_pkg::mem_req_t cmd;
    logic              busy;
    logic              done;
    logic [31:0]       rdata;

    string       op_name   [MAX_LINES];
    logic [23:0] addr_tab  [MAX_LINES];
    logic [31:0] wdata_tab [MAX_LINES];
    logic [31:0] exp_tab   [MAX_LINES];
    int          n_lines;
    int          checks;
    int          value_errors;
    int          other_errors;
    int          cycles;
    int          cycle_limit;

    mem_unit_top #(.ADDR_W(mem_pkg::ADDR_W)) u_dut (
        .clk, .rst, .cmd_valid, .cmd, .busy, .done, .rdata
    );

    always #4 clk = ~clk;

    // run limit, worked out from the golden length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles waiting for done", cycles);
            $display("checks: %0d, value errors: %0d, other errors: %0d",
                     checks, value_errors, other_errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic parse_op(input string s, output mem_pkg::mem_op_e op, output logic ok);
        ok = 1'b1;
        op = mem_pkg::op_fetch;
        if (s == "fetch")      op = mem_pkg::op_fetch;
        else if (s == "ld8")   op = mem_pkg::op_ld8;
        else if (s == "ld16")  op = mem_pkg::op_ld16;
        else if (s == "ld32")  op = mem_pkg::op_ld32;
        else if (s == "ld8s")  op = mem_pkg::op_ld8s;
        else if (s == "ld16s") op = mem_pkg::op_ld16s;
        else if (s == "st8")   op = mem_pkg::op_st8;
        else if (s == "st16")  op = mem_pkg::op_st16;
        else if (s == "st32")  op = mem_pkg::op_st32;
        else ok = 1'b0;
    endtask

    task automatic load_golden();
        int          fd;
        int          got;
        int          n;
        string       line;
        string       name;
        logic [23:0] a;
        logic [31:0] w;
        logic [31:0] e;
        n_lines = 0;
        fd = $fopen("tb/mem_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/mem_golden.txt for reading");
            other_errors++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                line = "";
                got  = $fgets(line, fd);
                if (got > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %h %h", name, a, w, e);
                    if (n == 4) begin
                        op_name[n_lines]   = name;
                        addr_tab[n_lines]  = a;
                        wdata_tab[n_lines] = w;
                        exp_tab[n_lines]   = e;
                        n_lines++;
                    end else begin
                        $display("golden line could not be parsed: %s", line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        mem_pkg::mem_op_e op;
        logic             ok;
        string            name;
        clk          = 1'b0;
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        cycles       = 0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        load_golden();
        cycle_limit = 40 * n_lines + 20;
        if (n_lines == 0) begin
            $display("golden file holds no commands");
            other_errors++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // nothing may move before the first command
        repeat (3) begin
            @(negedge clk);
            assert (!busy && !done) else begin
                $display("busy or done went high after reset with no command given");
                other_errors++;
            end
        end

        for (int i = 0; i < n_lines; i++) begin
            parse_op(op_name[i], op, ok);
            if (!ok) begin
                $display("unknown opcode name %s in golden line %0d", op_name[i], i);
                other_errors++;
            end else begin
                while (busy) @(negedge clk);
                @(posedge clk);
                cmd_valid <= 1'b1;
                cmd.op    <= op;
                cmd.addr  <= addr_tab[i];
                cmd.wdata <= wdata_tab[i];
                @(posedge clk);
                cmd_valid <= 1'b0;
                @(negedge clk);
                while (!done) @(negedge clk);  // timeout block catches a hang
                checks++;
                name = $sformatf("#%0d %s %06h", i, op_name[i], addr_tab[i]);
                assert (rdata == exp_tab[i]) else begin
                    $display("Fail %s: expected %08h, actual %08h", name, exp_tab[i], rdata);
                    value_errors++;
                end
            end
        end

        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/mem_golden.txt ====
# opcode name then byte address, write data and expected rdata, all hex
# memory starts at zero; loads and fetches read little-endian
st8   000100 000000a5 00000000
ld8   000100 00000000 000000a5
st8   000101 00000083 00000000
ld8s  000101 00000000 ffffff83
ld8   000101 00000000 00000083
ld16s 000100 00000000 ffff83a5
ld16  000100 00000000 000083a5
st16  000203 0000beef 00000000
ld16  000203 00000000 0000beef
st16  000206 0000c0de 00000000
ld16  000206 00000000 0000c0de
st32  000300 12345678 00000000
ld32  000300 00000000 12345678
st32  000305 89abcdef 00000000
ld32  000305 00000000 89abcdef
ld32  000301 00000000 00123456
fetch 000300 00000000 12345678
fetch 000301 00000000 00123456
fetch 000302 00000000 ef001234
fetch 000303 00000000 cdef0012
fetch 000305 00000000 89abcdef
fetch 000308 00000000 00000089
fetch 000300 00000000 12345678
fetch 000302 00000000 ef001234
fetch 000305 00000000 89abcdef
fetch 000204 00000000 c0de00be
st8   000205 0000005a 00000000
fetch 000204 00000000 c0de5abe

// ==== jt900h_mem.f ====
common/mem_pkg.sv
ramctl/mem_ram.sv
ramctl/mem_ramctl.sv
src/mem_decode.sv
src/mem_result.sv
src/mem_unit_top.sv
tb/mem_unit_tb.sv
